/* common/mem_noc_config.svh */
`ifndef MEM_NOC_CONFIG_SVH
`define MEM_NOC_CONFIG_SVH

// Flit and link sizing
`define MEM_NOC_FLIT_WIDTH 32
`define MEM_NOC_NUM_LINKS  4

// Header field widths where cid covers NUM_LINKS
`define MEM_NOC_CORD_WIDTH 4
`define MEM_NOC_LEN_WIDTH  4
`define MEM_NOC_CID_WIDTH  2

// Entries per input FIFO
`define MEM_NOC_BUF_DEPTH  2

`endif

/* common/mem_noc_pkg.sv */
`include "mem_noc_config.svh"

package mem_noc_pkg;

  localparam int mem_noc_addr_width_lp = `MEM_NOC_FLIT_WIDTH
                                       - `MEM_NOC_CORD_WIDTH
                                       - `MEM_NOC_LEN_WIDTH
                                       - `MEM_NOC_CID_WIDTH;

  // ************************************************************
  // Header view of a flit, MSB first
  // ************************************************************
  typedef struct packed {
    logic [`MEM_NOC_CORD_WIDTH-1:0] cord;  // Destination coordinate
    logic [`MEM_NOC_LEN_WIDTH-1:0]  len;   // Payload flits that follow
    logic [`MEM_NOC_CID_WIDTH-1:0]  cid;   // Return lane
    logic [mem_noc_addr_width_lp-1:0] addr;
  } mem_hdr_s;

  // Same word seen as header or as raw payload
  typedef union packed {
    mem_hdr_s                       hdr;
    logic [`MEM_NOC_FLIT_WIDTH-1:0] raw;
  } mem_flit_u;

  // ************************************************************
  // One-way link bundle with valid and ready_and
  // ************************************************************
  typedef struct packed {
    logic      v;
    logic      ready_and;  // Acceptance for the opposite direction
    mem_flit_u data;
  } mem_link_s;

endpackage

/* concentrator/wormhole_input_buffer.sv */
`timescale 1ns/1ps
`include "mem_noc_config.svh"

module wormhole_input_buffer
  import mem_noc_pkg::*;
(
  input  logic      mem_clk_i,
  input  logic      reset_i,
  input  mem_link_s link_i,
  output mem_link_s link_o,
  output mem_link_s head_o,
  input  logic      head_ready_i
);

  localparam int DEPTH = `MEM_NOC_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mem_flit_u        mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_r == CNT_W'(DEPTH));
  assign empty = (count_r == '0);
  assign wr_en = link_i.v & ~full;
  assign rd_en = ~empty & head_ready_i;

  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr_en) wr_ptr_r <= next_ptr(wr_ptr_r);
      if (rd_en) rd_ptr_r <= next_ptr(rd_ptr_r);
      case ({wr_en, rd_en})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;  // Idle or pass-through
      endcase
    end
  end

  always_ff @(posedge mem_clk_i) begin
    if (wr_en) mem_r[wr_ptr_r] <= link_i.data;
  end

  // Ready only from occupancy, head flit straight from storage
  always_comb begin
    link_o           = '0;
    link_o.ready_and = ~full;
    head_o           = '0;
    head_o.v         = ~empty;
    head_o.data      = mem_r[rd_ptr_r];
  end

endmodule

/* concentrator/wormhole_fwd_merge.sv */
`timescale 1ns/1ps
`include "mem_noc_config.svh"

module wormhole_fwd_merge
  import mem_noc_pkg::*;
(
  input  logic                                mem_clk_i,
  input  logic                                reset_i,
  input  mem_link_s [`MEM_NOC_NUM_LINKS-1:0]  heads_i,
  output logic      [`MEM_NOC_NUM_LINKS-1:0]  head_ready_o,
  output mem_link_s                           dram_cmd_link_o,
  input  logic                                dram_ready_i
);

  localparam int NUM_LINKS = `MEM_NOC_NUM_LINKS;
  localparam int LANE_W    = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1;
  localparam int LEN_W     = `MEM_NOC_LEN_WIDTH;

  // ************************************************************
  // State
  // ************************************************************
  mem_flit_u         out_r;
  logic              out_v_r;
  logic              locked_r;     // Grant held for a packet body
  logic [LANE_W-1:0] grant_r;
  logic [LANE_W-1:0] rr_ptr_r;     // First lane to look at
  logic [LEN_W-1:0]  remain_r;     // Payload flits still owed

  logic              load_en;
  logic              found;
  logic [LANE_W-1:0] pick;
  logic [LANE_W-1:0] sel;
  logic              sel_v;
  logic              take;
  mem_hdr_s          sel_hdr;

  function automatic logic [LANE_W-1:0] next_lane(input logic [LANE_W-1:0] lane);
    if (lane == LANE_W'(NUM_LINKS - 1)) begin
      return '0;
    end
    return lane + 1'b1;
  endfunction

  // Output register may refill on the edge it drains
  assign load_en = ~out_v_r | dram_ready_i;

  // ************************************************************
  // Round-robin search from rr_ptr_r
  // ************************************************************
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = rr_ptr_r;
    idx   = 0;
    for (int i = 0; i < NUM_LINKS; i++) begin
      idx = (int'(rr_ptr_r) + i) % NUM_LINKS;
      if (!found && heads_i[idx].v) begin
        found = 1'b1;
        pick  = idx[LANE_W-1:0];
      end
    end
  end

  // Locked lane wins, otherwise the fresh pick
  assign sel     = locked_r ? grant_r : pick;
  assign sel_v   = locked_r ? heads_i[grant_r].v : found;
  assign take    = sel_v & load_en;
  assign sel_hdr = heads_i[sel].data.hdr;  // Only meaningful when unlocked

  always_comb begin
    for (int n = 0; n < NUM_LINKS; n++) begin
      head_ready_o[n] = load_en & (sel == LANE_W'(n));
    end
  end

  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      out_v_r  <= 1'b0;
      locked_r <= 1'b0;
      grant_r  <= '0;
      rr_ptr_r <= '0;
      remain_r <= '0;
    end else begin
      if (load_en) out_v_r <= take;
      if (take) begin
        if (!locked_r) begin
          // Header flit
          if (sel_hdr.len != '0) begin
            locked_r <= 1'b1;
            grant_r  <= sel;
            remain_r <= sel_hdr.len;
          end else begin
            rr_ptr_r <= next_lane(sel);  // Header-only packet
          end
        end else begin
          remain_r <= remain_r - 1'b1;
          if (remain_r == LEN_W'(1)) begin
            locked_r <= 1'b0;  // Tail flit
            rr_ptr_r <= next_lane(grant_r);
          end
        end
      end
    end
  end

  always_ff @(posedge mem_clk_i) begin
    if (take) out_r <= heads_i[sel].data;
  end

  always_comb begin
    dram_cmd_link_o      = '0;
    dram_cmd_link_o.v    = out_v_r;
    dram_cmd_link_o.data = out_r;
  end

endmodule

/* concentrator/wormhole_rev_demux.sv */
`timescale 1ns/1ps
`include "mem_noc_config.svh"

module wormhole_rev_demux
  import mem_noc_pkg::*;
(
  input  logic                                mem_clk_i,
  input  logic                                reset_i,
  input  mem_link_s                           dram_resp_i,
  output logic                                dram_ready_o,
  output mem_link_s [`MEM_NOC_NUM_LINKS-1:0]  lanes_o,
  input  logic      [`MEM_NOC_NUM_LINKS-1:0]  lanes_ready_i
);

  localparam int NUM_LINKS = `MEM_NOC_NUM_LINKS;
  localparam int CID_W     = `MEM_NOC_CID_WIDTH;
  localparam int LEN_W     = `MEM_NOC_LEN_WIDTH;

  mem_flit_u        out_r;
  logic             out_v_r;
  logic [CID_W-1:0] cid_r;      // Lane of the flit in out_r
  logic [LEN_W-1:0] remain_r;
  logic             in_pkt_r;   // Next flit is payload
  mem_hdr_s         in_hdr;
  logic             take;

  assign in_hdr = dram_resp_i.data.hdr;

  // Free when empty or when the target lane drains us
  assign dram_ready_o = ~out_v_r | lanes_ready_i[cid_r];
  assign take         = dram_resp_i.v & dram_ready_o;

  // ************************************************************
  // Packet tracking
  // ************************************************************
  always_ff @(posedge mem_clk_i) begin
    if (reset_i) begin
      out_v_r  <= 1'b0;
      cid_r    <= '0;
      remain_r <= '0;
      in_pkt_r <= 1'b0;
    end else begin
      if (dram_ready_o) out_v_r <= take;
      if (take) begin
        if (!in_pkt_r) begin
          cid_r    <= in_hdr.cid;  // Held for the whole packet
          remain_r <= in_hdr.len;
          in_pkt_r <= (in_hdr.len != '0);
        end else begin
          remain_r <= remain_r - 1'b1;
          if (remain_r == LEN_W'(1)) in_pkt_r <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge mem_clk_i) begin
    if (take) out_r <= dram_resp_i.data;
  end

  // Data fans out to all lanes, valid only on the latched one
  always_comb begin
    for (int n = 0; n < NUM_LINKS; n++) begin
      lanes_o[n]      = '0;
      lanes_o[n].v    = out_v_r & (cid_r == CID_W'(n));
      lanes_o[n].data = out_r;
    end
  end

endmodule

/* design/mem_complex.sv */
`timescale 1ns/1ps
`include "mem_noc_config.svh"

module mem_complex
  import mem_noc_pkg::*;
(
  input  logic                                mem_clk_i,
  input  logic                                reset_i,
  input  mem_link_s [`MEM_NOC_NUM_LINKS-1:0]  mem_cmd_link_i,
  output mem_link_s [`MEM_NOC_NUM_LINKS-1:0]  mem_resp_link_o,
  output mem_link_s                           dram_cmd_link_o,
  input  mem_link_s                           dram_resp_link_i
);

  localparam int NUM_LINKS = `MEM_NOC_NUM_LINKS;

  mem_link_s [NUM_LINKS-1:0] buf_link;      // Head flits into the merge
  mem_link_s [NUM_LINKS-1:0] buf_rdy_link;  // Buffer ready back to columns
  logic      [NUM_LINKS-1:0] head_ready;
  logic      [NUM_LINKS-1:0] lane_ready;
  mem_link_s [NUM_LINKS-1:0] demux_lanes;
  mem_link_s                 merge_out;
  logic                      dram_ready;

  // ************************************************************
  // Forward path
  // ************************************************************
  for (genvar n = 0; n < NUM_LINKS; n++) begin : g_buf
    wormhole_input_buffer u_buf (
      .mem_clk_i    (mem_clk_i),
      .reset_i      (reset_i),
      .link_i       (mem_cmd_link_i[n]),
      .link_o       (buf_rdy_link[n]),
      .head_o       (buf_link[n]),
      .head_ready_i (head_ready[n])
    );
    assign lane_ready[n] = mem_cmd_link_i[n].ready_and;
  end

  wormhole_fwd_merge u_merge (
    .mem_clk_i       (mem_clk_i),
    .reset_i         (reset_i),
    .heads_i         (buf_link),
    .head_ready_o    (head_ready),
    .dram_cmd_link_o (merge_out),
    .dram_ready_i    (dram_resp_link_i.ready_and)
  );

  // Reverse path
  wormhole_rev_demux u_demux (
    .mem_clk_i     (mem_clk_i),
    .reset_i       (reset_i),
    .dram_resp_i   (dram_resp_link_i),
    .dram_ready_o  (dram_ready),
    .lanes_o       (demux_lanes),
    .lanes_ready_i (lane_ready)
  );

  always_comb begin
    for (int n = 0; n < NUM_LINKS; n++) begin
      mem_resp_link_o[n].v         = demux_lanes[n].v;
      mem_resp_link_o[n].data      = demux_lanes[n].data;
      mem_resp_link_o[n].ready_and = buf_rdy_link[n].ready_and;
    end
    dram_cmd_link_o.v         = merge_out.v;
    dram_cmd_link_o.data      = merge_out.data;
    dram_cmd_link_o.ready_and = dram_ready;
  end

endmodule

/* bench/mem_complex_tb.sv */
`timescale 1ns/1ps
`include "mem_noc_config.svh"

module mem_complex_tb
  import mem_noc_pkg::*;
();

  localparam int NUM_LINKS = `MEM_NOC_NUM_LINKS;
  localparam int CID_W     = `MEM_NOC_CID_WIDTH;
  localparam int LEN_W     = `MEM_NOC_LEN_WIDTH;
  localparam int MAX_LEN   = 6;
  localparam int NPKT_ALL  = 4;   // Per lane with all lanes at once
  localparam int NPKT_RAND = 5;   // Per lane under stalls
  localparam int NRESP     = 12;
  localparam int WORST_PKTS = NUM_LINKS + NUM_LINKS * NPKT_ALL
                            + NUM_LINKS * NPKT_RAND + NRESP;
  localparam int TIMEOUT_CYCLES = WORST_PKTS * (MAX_LEN + 1) * 20;

  logic                      clk = 1'b0;
  logic                      reset;
  mem_link_s [NUM_LINKS-1:0] cmd_link;
  mem_link_s [NUM_LINKS-1:0] resp_link;
  mem_link_s                 dram_cmd;
  mem_link_s                 dram_resp;

  int mismatch_cnt;
  int fault_cnt;
  int pkt_seq;

  mem_flit_u tx_q    [NUM_LINKS][$];  // Flits still to drive per lane
  mem_flit_u exp_fwd [NUM_LINKS][$];  // Scoreboard per lane
  mem_flit_u dram_q  [$];             // Everything seen on the DRAM link

  mem_complex dut (
    .mem_clk_i        (clk),
    .reset_i          (reset),
    .mem_cmd_link_i   (cmd_link),
    .mem_resp_link_o  (resp_link),
    .dram_cmd_link_o  (dram_cmd),
    .dram_resp_link_i (dram_resp)
  );

  always #4 clk = ~clk;

  // ************************************************************
  // Compare tasks
  // ************************************************************
  task automatic check_flit(input mem_flit_u got, input mem_flit_u exp, input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got.raw, exp.raw);
    end
  endtask

  task automatic check_lane(input logic [CID_W-1:0] got, input logic [CID_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_link(input mem_link_s got, input logic exp_v, input string what);
    if (got.v !== exp_v) begin
      mismatch_cnt++;
      $display("ERR %0t: %s valid is %b, expected %b", $time, what, got.v, exp_v);
    end
  endtask

  task automatic check_ready(input mem_link_s got, input logic exp_rdy, input string what);
    if (got.ready_and !== exp_rdy) begin
      mismatch_cnt++;
      $display("ERR %0t: %s ready is %b, expected %b", $time, what, got.ready_and, exp_rdy);
    end
  endtask

  // ************************************************************
  // Lane and DRAM drivers
  // ************************************************************
  task automatic build_packets(input int lane, input int npkt, input int fixed_len);
    mem_hdr_s    hdr;
    mem_flit_u   flit;
    logic [31:0] rnd;
    int          len;
    for (int p = 0; p < npkt; p++) begin
      len      = (fixed_len >= 0) ? fixed_len : $urandom_range(0, MAX_LEN);
      rnd      = $urandom();
      hdr.cord = '1;  // DRAM port coordinate
      hdr.len  = len[LEN_W-1:0];
      hdr.cid  = lane[CID_W-1:0];
      hdr.addr = rnd[mem_noc_addr_width_lp-1:0];
      flit.hdr = hdr;
      tx_q[lane].push_back(flit);
      exp_fwd[lane].push_back(flit);
      for (int i = 0; i < len; i++) begin
        flit.raw = 32'hD000_0000 | (32'(lane) << 24) | (32'(pkt_seq) << 8) | 32'(i);
        tx_q[lane].push_back(flit);
        exp_fwd[lane].push_back(flit);
      end
      pkt_seq++;
    end
  endtask

  // Returns just before the edge that moves the flit
  task automatic send_flit(input int lane, input mem_flit_u flit);
    @(negedge clk);
    cmd_link[lane].v    = 1'b1;
    cmd_link[lane].data = flit;
    #2;
    while (!resp_link[lane].ready_and) begin
      @(negedge clk);
      #2;
    end
  endtask

  task automatic drive_lane(input int lane, input bit gaps);
    while (tx_q[lane].size() > 0) begin
      if (gaps) begin
        repeat ($urandom_range(0, 2)) begin
          @(negedge clk);
          cmd_link[lane].v = 1'b0;
        end
      end
      send_flit(lane, tx_q[lane].pop_front());
    end
    @(negedge clk);
    cmd_link[lane].v = 1'b0;
  endtask

  task automatic collect_dram(input int total, input bit rand_ready);
    while (dram_q.size() < total) begin
      @(negedge clk);
      dram_resp.ready_and = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      #2;
      if (dram_cmd.v && dram_resp.ready_and) dram_q.push_back(dram_cmd.data);
    end
    repeat (4) begin  // Nothing extra may follow
      @(negedge clk);
      dram_resp.ready_and = 1'b1;
      #2;
      check_link(dram_cmd, 1'b0, "DRAM command link after last flit");
    end
  endtask

  // Splits the DRAM stream into packets and matches them per lane
  task automatic check_dram_stream(input bit rotation);
    mem_flit_u hdr_flit;
    mem_flit_u exp_hdr;
    int        lane;
    int        first_lane;
    int        pkt;
    pkt        = 0;
    first_lane = 0;
    while (dram_q.size() > 0) begin
      hdr_flit = dram_q.pop_front();
      lane     = int'(hdr_flit.hdr.cid);
      if (exp_fwd[lane].size() == 0) begin
        fault_cnt++;
        $display("Header %h on the DRAM link names lane %0d, which has nothing pending",
                 hdr_flit.raw, lane);
        continue;
      end
      exp_hdr = exp_fwd[lane].pop_front();
      check_flit(hdr_flit, exp_hdr, "packet header");
      if (pkt == 0) first_lane = lane;
      if (rotation) begin
        check_lane(hdr_flit.hdr.cid, CID_W'((first_lane + pkt) % NUM_LINKS),
                   "round-robin lane");
      end
      for (int i = 0; i < int'(exp_hdr.hdr.len); i++) begin
        if (dram_q.size() == 0 || exp_fwd[lane].size() == 0) begin
          fault_cnt++;
          $display("DRAM stream ended inside a packet from lane %0d", lane);
          break;
        end
        check_flit(dram_q.pop_front(), exp_fwd[lane].pop_front(), "packet payload");
      end
      pkt++;
    end
    for (int n = 0; n < NUM_LINKS; n++) begin
      if (exp_fwd[n].size() != 0) begin
        fault_cnt++;
        $display("%0d flits from lane %0d never reached the DRAM link", exp_fwd[n].size(), n);
        exp_fwd[n].delete();
      end
    end
  endtask

  task automatic run_traffic(input bit gaps, input bit rand_ready, input bit rotation);
    int total;
    total = 0;
    for (int n = 0; n < NUM_LINKS; n++) total += exp_fwd[n].size();
    for (int n = 0; n < NUM_LINKS; n++) begin
      fork
        automatic int lane = n;
        drive_lane(lane, gaps);
      join_none
    end
    collect_dram(total, rand_ready);
    wait fork;
    check_dram_stream(rotation);
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************
  task automatic test_reset_idle();
    @(negedge clk);
    #2;
    check_link(dram_cmd, 1'b0, "DRAM command link after reset");
    for (int n = 0; n < NUM_LINKS; n++) begin
      check_link(resp_link[n], 1'b0, $sformatf("response lane %0d after reset", n));
      check_ready(resp_link[n], 1'b1, $sformatf("command lane %0d after reset", n));
    end
  endtask

  task automatic test_single_lanes();
    for (int n = 0; n < NUM_LINKS; n++) begin
      build_packets(n, 1, 2 * n + 1);
      run_traffic(1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic test_all_lanes();
    for (int n = 0; n < NUM_LINKS; n++) build_packets(n, NPKT_ALL, -1);
    run_traffic(1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_random_stalls();
    for (int n = 0; n < NUM_LINKS; n++) build_packets(n, NPKT_RAND, -1);
    run_traffic(1'b1, 1'b1, 1'b0);
  endtask

  task automatic test_responses();
    mem_flit_u        src_flit [$];
    logic [CID_W-1:0] src_cid  [$];
    mem_flit_u        exp_flit [$];
    logic [CID_W-1:0] exp_cid  [$];
    mem_hdr_s         hdr;
    mem_flit_u        flit;
    logic [31:0]      rnd;
    logic [CID_W-1:0] head_cid;
    bit               head_v;
    bit               hold;
    int               len;
    int               cid;
    int               idx;
    for (int r = 0; r < NRESP; r++) begin
      rnd      = $urandom();
      len      = $urandom_range(0, MAX_LEN);
      cid      = $urandom_range(0, NUM_LINKS - 1);
      hdr.cord = '0;
      hdr.len  = len[LEN_W-1:0];
      hdr.cid  = cid[CID_W-1:0];
      hdr.addr = rnd[mem_noc_addr_width_lp-1:0];
      flit.hdr = hdr;
      src_flit.push_back(flit);
      src_cid.push_back(hdr.cid);
      for (int i = 0; i < len; i++) begin
        flit.raw = 32'hE000_0000 | (32'(r) << 8) | 32'(i);
        src_flit.push_back(flit);
        src_cid.push_back(hdr.cid);
      end
    end
    idx  = 0;
    hold = 1'b0;
    while (idx < src_flit.size() || exp_flit.size() > 0) begin
      @(negedge clk);
      for (int n = 0; n < NUM_LINKS; n++) cmd_link[n].ready_and = 1'($urandom_range(0, 1));
      if (!hold) begin
        dram_resp.v = (idx < src_flit.size()) && ($urandom_range(0, 3) != 0);
        if (dram_resp.v) dram_resp.data = src_flit[idx];
      end
      #2;
      // Oldest undelivered flit sits in the demux register
      head_v   = exp_flit.size() > 0;
      head_cid = head_v ? exp_cid[0] : '0;
      check_ready(dram_cmd, !head_v || cmd_link[head_cid].ready_and, "DRAM response");
      for (int n = 0; n < NUM_LINKS; n++) begin
        check_link(resp_link[n], head_v && (head_cid == CID_W'(n)),
                   $sformatf("response lane %0d", n));
        if (resp_link[n].v && cmd_link[n].ready_and && exp_flit.size() > 0) begin
          check_lane(CID_W'(n), exp_cid.pop_front(), "response lane");
          check_flit(resp_link[n].data, exp_flit.pop_front(), "response flit");
        end
      end
      if (dram_resp.v && dram_cmd.ready_and) begin
        exp_flit.push_back(src_flit[idx]);
        exp_cid.push_back(src_cid[idx]);
        idx++;
        hold = 1'b0;
      end else begin
        hold = dram_resp.v;
      end
    end
    @(negedge clk);
    dram_resp.v = 1'b0;
    for (int n = 0; n < NUM_LINKS; n++) cmd_link[n].ready_and = 1'b1;
  endtask

  // ************************************************************
  // Main sequence and watchdog
  // ************************************************************
  initial begin
    void'($urandom(66));
    mismatch_cnt = 0;
    fault_cnt    = 0;
    pkt_seq      = 0;
    reset        = 1'b1;
    cmd_link     = '0;
    dram_resp    = '0;
    for (int n = 0; n < NUM_LINKS; n++) cmd_link[n].ready_and = 1'b1;
    dram_resp.ready_and = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_idle();
    test_single_lanes();
    test_all_lanes();
    test_random_stalls();
    test_responses();

    $display("Summary: %0d value mismatches, %0d other failures", mismatch_cnt, fault_cnt);
    if (mismatch_cnt + fault_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: traffic did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+common
common/mem_noc_pkg.sv
concentrator/wormhole_input_buffer.sv
concentrator/wormhole_fwd_merge.sv
concentrator/wormhole_rev_demux.sv
design/mem_complex.sv
bench/mem_complex_tb.sv
